// File: fetch_pkg.sv
package fetch_pkg;

    // byte address on the fetch side
    typedef logic [31:0] addr_t;

    // clears the two byte-offset bits of an address
    localparam addr_t word_align_mask = 32'hffff_fffc;

    // MIPS reset vector in kseg1
    localparam addr_t boot_vector = 32'hbfc0_0000;

    // sequential fetch advance, one 32-bit instruction
    localparam addr_t inst_step = 32'd4;

endpackage

// File: isa_pkg.sv
package isa_pkg;

    // primary opcode field values used by the jump predecode
    localparam logic [5:0] op_j   = 6'b000010;
    localparam logic [5:0] op_jal = 6'b000011;
    localparam logic [5:0] op_beq = 6'b000100;

    // I format: opcode, two register fields, 16-bit immediate
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        // branch offset in words for beq
        logic [15:0] imm;
    } inst_i_t;

    // J format: opcode and 26-bit word index inside the current 256 MB region
    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] index;
    } inst_j_t;

    // one instruction word, read either as I or as J format
    // opcode sits in the same bits in both views
    typedef union packed {
        logic [31:0] raw;
        inst_i_t     i;
        inst_j_t     j;
    } inst_word_u;

endpackage

// File: pc.sv
`timescale 1ns/1ns

module pc #(
    parameter fetch_pkg::addr_t pc_initial_val = fetch_pkg::boot_vector
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             stall,
    input  logic             do_branch,
    input  logic             do_exception,
    input  logic             debug_reset,
    input  logic             do_debug,
    input  fetch_pkg::addr_t branch_addr,
    input  fetch_pkg::addr_t exception_addr,
    input  fetch_pkg::addr_t debug_addr,
    output fetch_pkg::addr_t pc_addr,
    output logic             redirect
);

    import fetch_pkg::*;

    // any redirect that is not a predecoded jump
    // the fetch register treats it as a flush
    assign redirect = debug_reset | do_exception | do_debug;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc_addr <= pc_initial_val;
        end
        // debug reset beats everything, even an exception in the same cycle
        else if (debug_reset)
        begin
            pc_addr <= pc_initial_val;
        end
        // exception vector may come in unaligned, force it to a word
        else if (do_exception)
        begin
            pc_addr <= exception_addr & word_align_mask;
        end
        else if (do_debug)
        begin
            pc_addr <= debug_addr;
        end
        // stall only freezes the branch and the sequential step
        else if (!stall)
        begin
            if (do_branch)
            begin
                pc_addr <= branch_addr;
            end
            else
            begin
                pc_addr <= pc_addr + inst_step;
            end
        end
    end

endmodule

// File: inst_rom.sv
`timescale 1ns/1ns

module inst_rom #(
    parameter int rom_addr_bits = 6
) (
    input  logic                     clk,
    input  logic                     load_en,
    input  logic [rom_addr_bits-1:0] load_addr,
    input  isa_pkg::inst_word_u      load_data,
    input  fetch_pkg::addr_t         pc_addr,
    output isa_pkg::inst_word_u      rom_data
);

    import isa_pkg::*;
    import fetch_pkg::*;

    // byte-offset bits below the word index, 2 for 4-byte instructions
    localparam int byte_bits = $clog2(inst_step);
    localparam int rom_words = 2 ** rom_addr_bits;

    inst_word_u mem [rom_words];

    // word index from the fetch address
    logic [rom_addr_bits-1:0] rd_index;

    // upper address bits dropped, so the image aliases across the space
    assign rd_index = pc_addr[byte_bits +: rom_addr_bits];

    // load port, single-cycle strobe
    always_ff @(posedge clk)
    begin
        if (load_en)
        begin
            mem[load_addr] <= load_data;
        end
    end

    // asynchronous read, the fetch register does the timing
    assign rom_data = mem[rd_index];

endmodule

// File: fetch_decode.sv
`timescale 1ns/1ns

module fetch_decode (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stall,
    input  logic                redirect,
    input  isa_pkg::inst_word_u rom_data,
    input  fetch_pkg::addr_t    pc_addr,
    output isa_pkg::inst_word_u inst,
    output fetch_pkg::addr_t    inst_pc,
    output fetch_pkg::addr_t    branch_addr,
    output logic                inst_valid,
    output logic                do_branch
);

    import isa_pkg::*;
    import fetch_pkg::*;

    // address of the delay slot, base for both target forms
    addr_t seq_pc;
    // sign-extended beq offset already scaled to bytes
    addr_t beq_offset;
    addr_t j_target;
    addr_t beq_target;
    logic  is_j;
    logic  is_beq_always;

    // valid flag
    // redirect empties the register even while stalled
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            inst_valid <= 1'b0;
        end
        else if (redirect)
        begin
            inst_valid <= 1'b0;
        end
        else if (!stall)
        begin
            inst_valid <= 1'b1;
        end
    end

    // word and its address, held under stall
    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            inst    <= rom_data;
            inst_pc <= pc_addr;
        end
    end

    // jump predecode on the held word

    assign seq_pc = inst_pc + inst_step;

    // j and jal share the region-relative target
    assign is_j = (inst.j.opcode == op_j) || (inst.j.opcode == op_jal);

    // beq $x, $x is always taken, no register file needed
    assign is_beq_always = (inst.i.opcode == op_beq) && (inst.i.rs == inst.i.rt);

    // keep the top nibble of the delay slot address
    assign j_target = {seq_pc[31:28], inst.j.index, 2'b00};

    assign beq_offset = {{14{inst.i.imm[15]}}, inst.i.imm, 2'b00};

    // backward offsets wrap through the add
    assign beq_target = (seq_pc + beq_offset) & word_align_mask;

    always_comb
    begin
        if (is_j)
        begin
            branch_addr = j_target;
        end
        else
        begin
            branch_addr = beq_target;
        end
    end

    // held jump keeps asserting until stall drops and pc takes it
    assign do_branch = inst_valid && (is_j || is_beq_always);

endmodule

// File: step_if.sv
`timescale 1ns/1ns

module step_if #(
    parameter fetch_pkg::addr_t pc_initial_val = fetch_pkg::boot_vector,
    parameter int               rom_addr_bits  = 6
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     stall,
    input  logic                     do_exception,
    input  logic                     do_debug,
    input  logic                     debug_reset,
    input  logic                     load_en,
    input  fetch_pkg::addr_t         exception_addr,
    input  fetch_pkg::addr_t         debug_addr,
    input  logic [rom_addr_bits-1:0] load_addr,
    input  isa_pkg::inst_word_u      load_data,
    output isa_pkg::inst_word_u      inst,
    output fetch_pkg::addr_t         inst_pc,
    output logic                     inst_valid
);

    import isa_pkg::*;
    import fetch_pkg::*;

    // current fetch address, feeds the store and the fetch register
    addr_t      pc_addr;
    // jump target coming back from predecode
    addr_t      branch_addr;
    logic       do_branch;
    // non-branch redirect, flushes the fetch register
    logic       redirect;
    inst_word_u rom_data;

    pc #(
        .pc_initial_val (pc_initial_val)
    ) u_pc (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall          (stall),
        .do_branch      (do_branch),
        .do_exception   (do_exception),
        .debug_reset    (debug_reset),
        .do_debug       (do_debug),
        .branch_addr    (branch_addr),
        .exception_addr (exception_addr),
        .debug_addr     (debug_addr),
        .pc_addr        (pc_addr),
        .redirect       (redirect)
    );

    inst_rom #(
        .rom_addr_bits (rom_addr_bits)
    ) u_inst_rom (
        .clk       (clk),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .pc_addr   (pc_addr),
        .rom_data  (rom_data)
    );

    // fetch register and jump predecode
    fetch_decode u_fetch_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .redirect    (redirect),
        .rom_data    (rom_data),
        .pc_addr     (pc_addr),
        .inst        (inst),
        .inst_pc     (inst_pc),
        .branch_addr (branch_addr),
        .inst_valid  (inst_valid),
        .do_branch   (do_branch)
    );

endmodule

// File: step_if_asserts.sv
`timescale 1ns/1ns

module step_if_asserts (
    input logic             clk,
    input logic             rst_n,
    input logic             stall,
    input logic             redirect,
    input logic             do_exception,
    input logic             inst_valid,
    input fetch_pkg::addr_t pc_addr
);

    // exception vector is masked before the counter takes it
    property exception_target_aligned;
        @(posedge clk) disable iff (!rst_n)
        do_exception |=> (pc_addr[1:0] == 2'b00);
    endproperty

    // flush empties the fetch register at the redirect edge
    property flush_after_redirect;
        @(posedge clk) disable iff (!rst_n)
        redirect |=> !inst_valid;
    endproperty

    // stall freezes both the step and a held jump
    property pc_frozen_under_stall;
        @(posedge clk) disable iff (!rst_n)
        (stall && !redirect) |=> $stable(pc_addr);
    endproperty

    exc_aligned: assert property (exception_target_aligned)
        else $error("pc_addr is not word aligned after an exception");

    redirect_flush: assert property (flush_after_redirect)
        else $error("inst_valid stayed high in the cycle after a redirect");

    stall_hold: assert property (pc_frozen_under_stall)
        else $error("pc_addr moved under stall without a redirect");

endmodule

bind step_if step_if_asserts u_step_if_asserts (
    .clk          (clk),
    .rst_n        (rst_n),
    .stall        (stall),
    .redirect     (redirect),
    .do_exception (do_exception),
    .inst_valid   (inst_valid),
    .pc_addr      (pc_addr)
);

// File: tb_step_if.sv
`timescale 1ns/1ns

module tb_step_if;

    import isa_pkg::*;
    import fetch_pkg::*;

    localparam int rom_addr_bits = 6;
    localparam int rom_words     = 2 ** rom_addr_bits;
    // cycles allowed between two consumed instructions
    localparam int wait_limit    = 200;

    logic                     clk;
    logic                     rst_n;
    logic                     stall;
    logic                     do_exception;
    logic                     do_debug;
    logic                     debug_reset;
    logic                     load_en;
    addr_t                    exception_addr;
    addr_t                    debug_addr;
    logic [rom_addr_bits-1:0] load_addr;
    inst_word_u               load_data;
    inst_word_u               inst;
    addr_t                    inst_pc;
    logic                     inst_valid;

    // fill pattern first with the load lines on top
    logic [31:0] image [rom_words];

    // one entry per cycle line
    int    cyc_count_q[$];
    int    cyc_stall_q[$];
    logic  cyc_exc_q[$];
    addr_t cyc_exc_addr_q[$];
    logic  cyc_dbg_q[$];
    addr_t cyc_dbg_addr_q[$];
    logic  cyc_dreset_q[$];

    // consumed stream in order
    addr_t       exp_pc_q[$];
    logic [31:0] exp_inst_q[$];

    integer seed;
    int     checked;

    step_if DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall          (stall),
        .do_exception   (do_exception),
        .do_debug       (do_debug),
        .debug_reset    (debug_reset),
        .load_en        (load_en),
        .exception_addr (exception_addr),
        .debug_addr     (debug_addr),
        .load_addr      (load_addr),
        .load_data      (load_data),
        .inst           (inst),
        .inst_pc        (inst_pc),
        .inst_valid     (inst_valid)
    );

    // 40 ns period
    always
    begin
        #20 clk = ~clk;
    end

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            stop_on_error($sformatf("Mismatch %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    task automatic read_stim_file;
        int            fd;
        int            rc;
        int            i;
        string         kind;
        logic [1023:0] skip_buf;
        logic [31:0]   f_a;
        logic [31:0]   f_b;
        logic [31:0]   f_exc_addr;
        logic [31:0]   f_dbg_addr;
        int            f_count;
        int            f_stall;
        int            f_exc;
        int            f_dbg;
        int            f_dreset;
        fd = $fopen("stim_step_if.txt", "r");
        if (fd == 0)
        begin
            stop_on_error("could not open stim_step_if.txt");
        end
        // every word gets a value that depends on its index
        for (i = 0; i < rom_words; i++)
        begin
            image[i] = 32'h2400_0000 | 32'(i);
        end
        while ($fscanf(fd, "%s", kind) == 1)
        begin
            if (kind == "#")
            begin
                rc = $fgets(skip_buf, fd);
            end
            else if (kind == "L")
            begin
                rc = $fscanf(fd, "%h %h", f_a, f_b);
                if (rc != 2 || f_a >= rom_words)
                begin
                    stop_on_error("a load line in stim_step_if.txt is malformed");
                end
                i = int'(f_a);
                image[i] = f_b;
            end
            else if (kind == "C")
            begin
                rc = $fscanf(fd, "%d %d %d %h %d %h %d", f_count, f_stall, f_exc,
                             f_exc_addr, f_dbg, f_dbg_addr, f_dreset);
                if (rc != 7)
                begin
                    stop_on_error("a cycle line in stim_step_if.txt is malformed");
                end
                cyc_count_q.push_back(f_count);
                cyc_stall_q.push_back(f_stall);
                cyc_exc_q.push_back(f_exc != 0);
                cyc_exc_addr_q.push_back(f_exc_addr);
                cyc_dbg_q.push_back(f_dbg != 0);
                cyc_dbg_addr_q.push_back(f_dbg_addr);
                cyc_dreset_q.push_back(f_dreset != 0);
            end
            else if (kind == "E")
            begin
                rc = $fscanf(fd, "%h %h", f_a, f_b);
                if (rc != 2)
                begin
                    stop_on_error("an expect line in stim_step_if.txt is malformed");
                end
                exp_pc_q.push_back(f_a);
                exp_inst_q.push_back(f_b);
            end
            else
            begin
                stop_on_error("stim_step_if.txt holds a line of unknown kind");
            end
        end
        $fclose(fd);
    endtask

    // one word per cycle through the load port while reset is held low
    task automatic load_image;
        int i;
        for (i = 0; i < rom_words; i++)
        begin
            @(posedge clk);
            #2;
            load_en        = 1'b1;
            load_addr      = rom_addr_bits'(i);
            load_data.raw  = image[i];
        end
        @(posedge clk);
        #2;
        load_en = 1'b0;
    endtask

    task automatic drive_line(input int n);
        if (cyc_stall_q[n] == 2)
        begin
            // one chance in four
            stall = (($random(seed) & 3) == 0);
        end
        else
        begin
            stall = (cyc_stall_q[n] != 0);
        end
        do_exception   = cyc_exc_q[n];
        exception_addr = cyc_exc_addr_q[n];
        do_debug       = cyc_dbg_q[n];
        debug_addr     = cyc_dbg_addr_q[n];
        debug_reset    = cyc_dreset_q[n];
    endtask

    // each line is held for its count of cycles, starting 2 ns after an edge
    task automatic apply_cycles;
        int n;
        int k;
        for (n = 0; n < cyc_count_q.size(); n++)
        begin
            for (k = 0; k < cyc_count_q[n]; k++)
            begin
                drive_line(n);
                @(posedge clk);
                #2;
            end
        end
        // free running after the last line
        stall        = 1'b0;
        do_exception = 1'b0;
        do_debug     = 1'b0;
        debug_reset  = 1'b0;
    endtask

    // returns at a falling edge before which the next rising edge consumes
    task automatic await_consumption;
        int waited;
        waited = 0;
        @(negedge clk);
        while (!(inst_valid === 1'b1 && stall === 1'b0))
        begin
            waited++;
            if (waited >= wait_limit)
            begin
                stop_on_error("no instruction was consumed within 200 cycles");
            end
            @(negedge clk);
        end
    endtask

    task automatic check_stream;
        int n;
        for (n = 0; n < exp_pc_q.size(); n++)
        begin
            await_consumption();
            check_value("inst_pc", inst_pc, exp_pc_q[n]);
            check_value("inst", inst.raw, exp_inst_q[n]);
            checked++;
        end
    endtask

    initial
    begin
        seed           = 32'h2eb3_932e;
        checked        = 0;
        clk            = 1'b0;
        rst_n          = 1'b0;
        stall          = 1'b0;
        do_exception   = 1'b0;
        do_debug       = 1'b0;
        debug_reset    = 1'b0;
        load_en        = 1'b0;
        exception_addr = '0;
        debug_addr     = '0;
        load_addr      = '0;
        load_data      = '0;
        read_stim_file();
        load_image();
        // three more reset cycles after the image is in
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        fork
            apply_cycles();
        join_none
        check_stream();
        if (checked > 0)
        begin
            $display("Regression passed");
            $finish;
        end
        else
        begin
            stop_on_error("the expected instruction list was empty");
        end
    end

endmodule

// File: stim_step_if.txt
# L idx data : word index (hex) and word, other words hold the fill 240000xx
# C count stall exc exc_addr dbg dbg_addr dreset : held count cycles, stall 2 is random
# E inst_pc inst : next consumed instruction, in order
# j to bfc00040
L 04 0bf00010
# jal to bfc00080
L 12 0ff00020
# beq $1,$1 backward to bfc00060
L 22 1021fff5
# beq $2,$2 forward to bfc000a0
L 1a 1042000d
# straight run through the j
C 9 0 0 00000000 0 00000000 0
# stall while the jal sits in the fetch register
C 2 1 0 00000000 0 00000000 0
C 11 0 0 00000000 0 00000000 0
# unaligned exception, bfc000a8 is in flight and dropped
C 1 0 1 bfc000c3 0 00000000 0
C 2 0 0 00000000 0 00000000 0
# exception under stall, bfc000c4 is held and never consumed
C 1 1 1 bfc000e2 0 00000000 0
C 2 0 0 00000000 0 00000000 0
# debug jump
C 1 0 0 00000000 1 bfc00030 0
C 2 0 0 00000000 0 00000000 0
# debug reset together with an exception
C 1 0 1 bfc000a1 0 00000000 1
C 1 0 0 00000000 0 00000000 0
# random stall over the same jumps
C 60 2 0 00000000 0 00000000 0
# boot run and j with delay slot
E bfc00000 24000000
E bfc00004 24000001
E bfc00008 24000002
E bfc0000c 24000003
E bfc00010 0bf00010
E bfc00014 24000005
E bfc00040 24000010
E bfc00044 24000011
# jal held under stall, then slot and target
E bfc00048 0ff00020
E bfc0004c 24000013
E bfc00080 24000020
E bfc00084 24000021
# backward beq
E bfc00088 1021fff5
E bfc0008c 24000023
E bfc00060 24000018
E bfc00064 24000019
# forward beq
E bfc00068 1042000d
E bfc0006c 2400001b
E bfc000a0 24000028
E bfc000a4 24000029
# exception target with low bits cleared
E bfc000c0 24000030
# exception taken under stall
E bfc000e0 24000038
E bfc000e4 24000039
# debug target
E bfc00030 2400000c
E bfc00034 2400000d
# debug reset wins over the exception
E bfc00000 24000000
# random stall section
E bfc00004 24000001
E bfc00008 24000002
E bfc0000c 24000003
E bfc00010 0bf00010
E bfc00014 24000005
E bfc00040 24000010
E bfc00044 24000011
E bfc00048 0ff00020
E bfc0004c 24000013
E bfc00080 24000020
E bfc00084 24000021
E bfc00088 1021fff5
E bfc0008c 24000023
E bfc00060 24000018
E bfc00064 24000019
E bfc00068 1042000d
E bfc0006c 2400001b
E bfc000a0 24000028
E bfc000a4 24000029
E bfc000a8 2400002a

// File: compile.f
fetch_pkg.sv
isa_pkg.sv
pc.sv
inst_rom.sv
fetch_decode.sv
step_if.sv
step_if_asserts.sv
tb_step_if.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_step_if
FILELIST  := compile.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(OBJ_DIR)
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := fetch_pkg.sv isa_pkg.sv pc.sv inst_rom.sv fetch_decode.sv step_if.sv \
             step_if_asserts.sv tb_step_if.sv

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# exit status of the simulation is the verdict
run: $(SIM_BIN) stim_step_if.txt
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
